// ==== source/icache_pkg.sv ====
/* icache shared definitions
   address and word types, AXI burst encodings, controller states */
package icache_pkg;

	typedef logic [31:0] addr_t; // physical byte address
	typedef logic [31:0] word_t; // one instruction, also one AXI beat

	// AXI read burst encodings
	localparam logic [2:0] AXI_SIZE_4     = 3'b010; // 4-byte beats
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;

	// controller sequence
	typedef enum logic [2:0] {
		s_idle     = 3'd0,
		s_check    = 3'd1,
		s_addr_req = 3'd2,
		s_load     = 3'd3,
		s_pass     = 3'd4,
		s_update   = 3'd5,
		s_fence    = 3'd7
	} icache_state_e;

endpackage

// ==== source/cache_array_if.sv ====
`timescale 1ns/1ps
/* controller to tag/data array link
   lookup results one way, fill and invalidate strobes the other */
interface cache_array_if import icache_pkg::*; #(
	parameter int INDEX_W  = 4,
	parameter int OFFSET_W = 4
);
	localparam int TAG_W = $bits(addr_t) - INDEX_W - OFFSET_W;

	logic [INDEX_W-1:0] index; // line index of the fetch address
	logic [TAG_W-1:0]   tag;
	logic               hit;
	word_t              word;  // word at the fetch offset

	logic  fill_beat;      // one refill beat into the indexed line
	word_t fill_data;
	logic  commit;         // write tag, set valid
	logic  invalidate_all; // fence.i

	modport controller (
		input  index, tag, hit, word,
		output fill_beat, fill_data, commit, invalidate_all
	);

	modport arrays (
		output index, tag, hit, word,
		input  fill_beat, fill_data, commit, invalidate_all
	);
endinterface

// ==== source/refill_if.sv ====
`timescale 1ns/1ps
/* controller to burst refill engine link */
interface refill_if import icache_pkg::*; #(
	parameter int INDEX_W  = 4,
	parameter int OFFSET_W = 4
);
	localparam int TAG_W = $bits(addr_t) - INDEX_W - OFFSET_W;

	logic                     start;     // one-cycle pulse
	logic [TAG_W+INDEX_W-1:0] line_addr; // tag and index, offset implied zero
	logic                     busy_load; // address accepted, taking beats
	logic                     beat_valid;
	word_t                    beat_data;
	logic                     done;      // with the rlast beat

	modport controller (output start, line_addr,
		input busy_load, beat_valid, beat_data, done);

	modport refill (input start, line_addr,
		output busy_load, beat_valid, beat_data, done);
endinterface

// ==== source/icache_arrays.sv ====
`timescale 1ns/1ps
/* icache tag, valid and data storage
   direct-mapped compare, word select, beat-wise line fill, invalidate-all */
module icache_arrays import icache_pkg::*; #(
	parameter int INDEX_W  = 4,
	parameter int OFFSET_W = 4
) (
	input  logic          clock,
	input  logic          reset,
	input  addr_t         paddr,
	cache_array_if.arrays arr
);
	localparam int TAG_W  = $bits(addr_t) - INDEX_W - OFFSET_W;
	localparam int LINES  = 2 ** INDEX_W;
	localparam int LINE_W = (2 ** OFFSET_W) * 8;
	localparam int WORD_W = $bits(word_t);

	typedef logic [TAG_W-1:0]  tag_t;
	typedef logic [LINE_W-1:0] line_t;

	logic [LINES-1:0]    valid_q;
	tag_t                tag_q  [LINES];
	line_t               line_q [LINES];
	logic [OFFSET_W-1:0] offset;
	line_t               sel_line;

	// address split
	assign arr.tag   = paddr[$bits(addr_t)-1 -: TAG_W];
	assign arr.index = paddr[OFFSET_W +: INDEX_W];
	assign offset    = paddr[OFFSET_W-1:0];

	assign arr.hit = valid_q[arr.index] && (tag_q[arr.index] == arr.tag);

	// byte offset to bit shift, low two offset bits are zero for aligned fetches
	assign sel_line = line_q[arr.index] >> {offset, 3'b000};
	assign arr.word = sel_line[WORD_W-1:0];

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else if (arr.invalidate_all) begin
			valid_q <= '0; // fence.i drops every line
		end else if (arr.commit) begin
			valid_q[arr.index] <= 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (arr.commit) begin
			tag_q[arr.index] <= arr.tag;
		end
	end

	/* each beat enters at the top word and the line moves down one word,
	   so after the last beat the first beat sits at word 0 */
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < LINES; i++) begin
				line_q[i] <= '0;
			end
		end else if (arr.fill_beat) begin
			line_q[arr.index] <= (line_q[arr.index] >> WORD_W)
				| (line_t'(arr.fill_data) << (LINE_W - WORD_W));
		end
	end

endmodule

// ==== source/line_refill.sv ====
`timescale 1ns/1ps
/* AXI read master for line refills
   one incrementing burst per line, beats streamed back to the controller */
module line_refill import icache_pkg::*; #(
	parameter int INDEX_W  = 4,
	parameter int OFFSET_W = 4
) (
	input  logic          clock,
	input  logic          reset,
	refill_if.refill      rfl,
	output addr_t         araddr,
	output logic          arvalid,
	input  logic          arready,
	output logic [7:0]    arlen,
	output logic [2:0]    arsize,
	output logic [1:0]    arburst,
	input  logic          rvalid,
	input  logic          rlast,
	input  word_t         rdata,
	output logic          rready
);
	localparam int TAG_W = $bits(addr_t) - INDEX_W - OFFSET_W;
	localparam int BEATS = (2 ** OFFSET_W) / ($bits(word_t) / 8);

	logic [TAG_W+INDEX_W-1:0] line_q; // latched line number
	logic                     arvalid_q;
	logic                     rready_q;
	logic                     beat;

	always_ff @(posedge clock) begin
		if (rfl.start) begin
			line_q <= rfl.line_addr;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			arvalid_q <= 1'b0;
			rready_q  <= 1'b0;
		end else begin
			if (rfl.start) begin
				arvalid_q <= 1'b1;
			end else if (arvalid_q && arready) begin
				arvalid_q <= 1'b0; // address taken, move to data phase
				rready_q  <= 1'b1;
			end
			if (beat && rlast) begin
				rready_q <= 1'b0;
			end
		end
	end

	assign beat = rready_q && rvalid;

	// address channel
	assign araddr  = {line_q, {OFFSET_W{1'b0}}};
	assign arvalid = arvalid_q;
	assign arlen   = 8'(BEATS - 1);
	assign arsize  = AXI_SIZE_4;
	assign arburst = AXI_BURST_INCR;

	// data channel
	assign rready = rready_q;

	assign rfl.busy_load  = rready_q;
	assign rfl.beat_valid = beat;
	assign rfl.beat_data  = rdata;
	assign rfl.done       = beat && rlast;

endmodule

// ==== source/icache_control.sv ====
`timescale 1ns/1ps
/* icache controller
   sequences lookup, refill, line update, answer and fence.i */
module icache_control import icache_pkg::*; #(
	parameter int INDEX_W  = 4,
	parameter int OFFSET_W = 4
) (
	input  logic              clock,
	input  logic              reset,
	input  addr_t             paddr,
	input  logic              psel,
	input  logic              fence_flag,
	output logic              pready,
	output word_t             prdata,
	cache_array_if.controller arr,
	refill_if.controller      rfl
);
	icache_state_e state;
	icache_state_e next_state;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= s_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			s_idle: begin
				if (psel) begin
					next_state = s_check;
				end else if (fence_flag) begin
					next_state = s_fence; // psel wins over fence
				end
			end
			s_check: begin
				if (arr.hit) begin
					next_state = s_pass;
				end else begin
					next_state = s_addr_req;
				end
			end
			s_addr_req: begin
				// a short line can finish before load is ever seen
				if (rfl.done) begin
					next_state = s_update;
				end else if (rfl.busy_load) begin
					next_state = s_load;
				end
			end
			s_load: begin
				if (rfl.done) begin
					next_state = s_update;
				end
			end
			s_update: begin
				next_state = s_pass;
			end
			s_pass: begin
				if (psel) begin
					next_state = s_check; // back-to-back fetch
				end else begin
					next_state = s_idle;
				end
			end
			s_fence: begin
				next_state = s_idle;
			end
			default: begin
				next_state = s_idle;
			end
		endcase
	end

	// refill request on a miss
	assign rfl.start     = (state == s_check) && !arr.hit;
	assign rfl.line_addr = {paddr[$bits(addr_t)-1:INDEX_W+OFFSET_W], arr.index};

	assign arr.fill_beat      = rfl.beat_valid;
	assign arr.fill_data      = rfl.beat_data;
	assign arr.commit         = (state == s_update);
	assign arr.invalidate_all = (state == s_fence);

	// answer to the fetch unit
	assign pready = (state == s_pass);
	assign prdata = arr.word;

endmodule

// ==== source/icache_top.sv ====
`timescale 1ns/1ps
/* direct-mapped read-only instruction cache
   fetch port toward the core, AXI read burst port toward DRAM */
module icache_top import icache_pkg::*; #(
	parameter int INDEX_W  = 4, // 16 lines
	parameter int OFFSET_W = 4  // 16-byte lines
) (
	input  logic       clock,
	input  logic       reset,
	// fetch side
	input  addr_t      in_paddr,
	input  logic       in_psel,
	output logic       in_pready,
	output word_t      in_prdata,
	input  logic       in_fence_flag,
	// DRAM side
	output addr_t      out_araddr,
	output logic       out_arvalid,
	input  logic       out_arready,
	output logic [7:0] out_arlen,
	output logic [2:0] out_arsize,
	output logic [1:0] out_arburst,
	input  logic       out_rvalid,
	input  logic       out_rlast,
	input  word_t      out_rdata,
	output logic       out_rready
);
	cache_array_if #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) arr_bus ();
	refill_if      #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) refill_bus ();

	icache_control #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_control (
		.clock      (clock),
		.reset      (reset),
		.paddr      (in_paddr),
		.psel       (in_psel),
		.fence_flag (in_fence_flag),
		.pready     (in_pready),
		.prdata     (in_prdata),
		.arr        (arr_bus.controller),
		.rfl        (refill_bus.controller)
	);

	icache_arrays #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_arrays (
		.clock (clock),
		.reset (reset),
		.paddr (in_paddr),
		.arr   (arr_bus.arrays)
	);

	line_refill #(.INDEX_W(INDEX_W), .OFFSET_W(OFFSET_W)) u_refill (
		.clock   (clock),
		.reset   (reset),
		.rfl     (refill_bus.refill),
		.araddr  (out_araddr),
		.arvalid (out_arvalid),
		.arready (out_arready),
		.arlen   (out_arlen),
		.arsize  (out_arsize),
		.arburst (out_arburst),
		.rvalid  (out_rvalid),
		.rlast   (out_rlast),
		.rdata   (out_rdata),
		.rready  (out_rready)
	);

endmodule

// ==== sim/axi_dram_model.sv ====
`timescale 1ns/1ps
/* DRAM stand-in on the AXI read channels
   answers incrementing bursts with random stalls, logs each address request */
module axi_dram_model import icache_pkg::*; (
	input  logic       clock,
	input  logic       reset,
	input  addr_t      araddr,
	input  logic       arvalid,
	output logic       arready,
	input  logic [7:0] arlen,
	input  logic [2:0] arsize,
	input  logic [1:0] arburst,
	output logic       rvalid,
	output logic       rlast,
	output word_t      rdata,
	input  logic       rready,
	output int         ar_count, // address handshakes so far
	output addr_t      ar_addr,  // fields of the latest request
	output logic [7:0] ar_len,
	output logic [2:0] ar_size,
	output logic [1:0] ar_burst
);
	function automatic word_t dram_word(addr_t a);
		return ~a ^ 32'h5a5a5a5a;
	endfunction

	initial begin : serve
		addr_t      base;
		logic [7:0] len;
		logic [2:0] size;
		logic [1:0] burst;
		int         stall;
		bit         taken;

		arready  = 1'b0;
		rvalid   = 1'b0;
		rlast    = 1'b0;
		rdata    = '0;
		ar_count = 0;
		ar_addr  = '0;
		ar_len   = '0;
		ar_size  = '0;
		ar_burst = '0;
		forever begin
			@(negedge clock);
			if (!reset && arvalid) begin
				base  = araddr; // held stable while arvalid waits
				len   = arlen;
				size  = arsize;
				burst = arburst;
				stall = $urandom_range(3);
				repeat (stall) @(posedge clock);
				@(posedge clock);
				arready <= 1'b1;
				@(posedge clock); // address handshake
				arready  <= 1'b0;
				ar_count <= ar_count + 1;
				ar_addr  <= base;
				ar_len   <= len;
				ar_size  <= size;
				ar_burst <= burst;
				for (int b = 0; b <= int'(len); b++) begin
					stall = $urandom_range(3);
					if (stall != 0) begin
						rvalid <= 1'b0;
						repeat (stall) @(posedge clock);
					end
					rvalid <= 1'b1;
					rdata  <= dram_word(base + addr_t'(4 * b)); // incrementing beats
					rlast  <= (b == int'(len));
					taken = 1'b0;
					while (!taken) begin
						@(negedge clock);
						taken = rready;
						@(posedge clock); // beat goes across here when rready was high
					end
				end
				rvalid <= 1'b0;
				rlast  <= 1'b0;
			end
		end
	end

endmodule

// ==== sim/icache_tb.sv ====
`timescale 1ns/1ps
/* icache testbench
   directed and random fetches checked against a tag mirror and the DRAM data rule */
module icache_tb import icache_pkg::*; ();
	localparam int CLK_HALF        = 20;
	localparam int RESET_CYCLES    = 16;
	localparam int STREAM_LEN      = 400;
	localparam int TOTAL_FETCHES   = 12 + STREAM_LEN;
	localparam int WATCHDOG_CYCLES = TOTAL_FETCHES * 40 + 2000;
	localparam int FETCH_TIMEOUT   = 100; // in cycles and far above a fully stalled refill

	logic       clock;
	logic       reset;
	addr_t      in_paddr;
	logic       in_psel;
	logic       in_fence_flag;
	logic       in_pready;
	word_t      in_prdata;
	addr_t      out_araddr;
	logic       out_arvalid;
	logic       out_arready;
	logic [7:0] out_arlen;
	logic [2:0] out_arsize;
	logic [1:0] out_arburst;
	logic       out_rvalid;
	logic       out_rlast;
	word_t      out_rdata;
	logic       out_rready;
	int         dram_ar_count;
	addr_t      dram_ar_addr;
	logic [7:0] dram_ar_len;
	logic [2:0] dram_ar_size;
	logic [1:0] dram_ar_burst;

	// tag mirror for 16 lines of 16 bytes with index addr[7:4] and tag addr[31:8]
	logic        ref_valid [16];
	logic [23:0] ref_tag   [16];

	int    errors;
	int    checks;
	int    test_errors_base;
	bit    chained; // psel held through the last pass so the next request is already taken
	addr_t stream_addr  [STREAM_LEN];
	int    stream_gap   [STREAM_LEN];
	bit    stream_fence [STREAM_LEN];

	icache_top #(.INDEX_W(4), .OFFSET_W(4)) DUT (
		.clock (clock), .reset (reset),
		.in_paddr (in_paddr), .in_psel (in_psel), .in_pready (in_pready),
		.in_prdata (in_prdata), .in_fence_flag (in_fence_flag),
		.out_araddr (out_araddr), .out_arvalid (out_arvalid), .out_arready (out_arready),
		.out_arlen (out_arlen), .out_arsize (out_arsize), .out_arburst (out_arburst),
		.out_rvalid (out_rvalid), .out_rlast (out_rlast), .out_rdata (out_rdata),
		.out_rready (out_rready)
	);

	axi_dram_model dram (
		.clock (clock), .reset (reset),
		.araddr (out_araddr), .arvalid (out_arvalid), .arready (out_arready),
		.arlen (out_arlen), .arsize (out_arsize), .arburst (out_arburst),
		.rvalid (out_rvalid), .rlast (out_rlast), .rdata (out_rdata), .rready (out_rready),
		.ar_count (dram_ar_count), .ar_addr (dram_ar_addr), .ar_len (dram_ar_len),
		.ar_size (dram_ar_size), .ar_burst (dram_ar_burst)
	);

	initial clock = 1'b0;
	always #(CLK_HALF) clock = ~clock;

	function automatic word_t expected_word(addr_t a);
		return ~a ^ 32'h5a5a5a5a;
	endfunction

	// predicts a hit and installs the line on a miss
	function automatic bit lookup_model(addr_t a);
		int idx;
		bit hit;
		idx = int'(a[7:4]);
		hit = ref_valid[idx] && (ref_tag[idx] == a[31:8]);
		ref_valid[idx] = 1'b1;
		ref_tag[idx]   = a[31:8];
		return hit;
	endfunction

	// three tags over six indices and four words
	function automatic addr_t make_addr(int tag_sel, int idx, int wd);
		addr_t tag;
		case (tag_sel)
			0: tag = 32'h0000_0010;
			1: tag = 32'h0000_0011;
			default: tag = 32'h0000_03c2;
		endcase
		return (tag << 8) | (addr_t'(idx) << 4) | (addr_t'(wd) << 2);
	endfunction

	task automatic run_fetch(input addr_t a, input int gap, input bit keep,
			output bit missed, output bit saw_ar);
		bit hit;
		bit got;
		int ar_before;
		int wait_cycles;

		hit       = lookup_model(a);
		missed    = !hit;
		ar_before = dram_ar_count;
		if (chained) begin
			in_paddr <= a; // check state sees the new address after this edge
		end else begin
			repeat (gap) @(posedge clock);
			@(posedge clock);
			in_psel  <= 1'b1;
			in_paddr <= a;
			@(posedge clock); // psel sampled here in idle
		end
		in_psel <= keep;
		got = 1'b0;
		wait_cycles = 0;
		while (!got && wait_cycles < FETCH_TIMEOUT) begin
			@(negedge clock);
			wait_cycles++;
			got = in_pready;
		end
		if (!got) begin
			$display("fetch to %h never got a ready pulse", a);
			errors++;
		end else begin
			checks++;
			if (in_prdata !== expected_word(a)) begin
				$display("error in_prdata at %h expected %h got %h", a, expected_word(a), in_prdata);
				errors++;
			end
			// no refill left in flight while answering
			checks++;
			if (out_arvalid !== 1'b0 || out_rready !== 1'b0) begin
				$display("error out_arvalid/out_rready at %h expected 0/0 got %h/%h", a,
					out_arvalid, out_rready);
				errors++;
			end
			checks++;
			if (dram_ar_count - ar_before != (hit ? 0 : 1)) begin
				$display("error ar_requests at %h expected %h got %h", a, (hit ? 0 : 1),
					dram_ar_count - ar_before);
				errors++;
			end else if (!hit) begin
				checks++;
				if (dram_ar_addr !== {a[31:4], 4'h0}) begin
					$display("error out_araddr expected %h got %h", {a[31:4], 4'h0}, dram_ar_addr);
					errors++;
				end
				if (dram_ar_len !== 8'h03 || dram_ar_size !== 3'h2 || dram_ar_burst !== 2'h1) begin
					$display("error out_arlen/out_arsize/out_arburst expected 03/2/1 got %h/%h/%h",
						dram_ar_len, dram_ar_size, dram_ar_burst);
					errors++;
				end
			end else begin
				checks++;
				if (wait_cycles != 2) begin
					$display("error in_pready latency at %h expected %h got %h", a, 2, wait_cycles);
					errors++;
				end
			end
		end
		saw_ar = (dram_ar_count != ar_before);
		if (keep) begin
			@(posedge clock); // the next request is taken at this edge
		end
		chained = keep;
	endtask

	task automatic issue_fence();
		@(posedge clock);
		in_fence_flag <= 1'b1;
		@(posedge clock);
		in_fence_flag <= 1'b0; // taken in idle here
		@(posedge clock);
		for (int i = 0; i < 16; i++) begin
			ref_valid[i] = 1'b0;
		end
	endtask

	task automatic expect_refill(input addr_t a, input bit want, input bit saw_ar);
		checks++;
		if (want && !saw_ar) begin
			$display("fetch to %h should have refilled but hit", a);
			errors++;
		end else if (!want && saw_ar) begin
			$display("fetch to %h should have hit but refilled", a);
			errors++;
		end
	endtask

	task automatic report_test(input string name);
		$display("test %s finished with %0d errors", name, errors - test_errors_base);
		test_errors_base = errors;
	endtask

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles, the run is stuck", WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

	initial begin : stimulus
		bit miss;
		bit saw;
		bit keep;
		int misses;
		int ar_start;

		void'($urandom(37));
		reset         = 1'b1;
		in_paddr      = '0;
		in_psel       = 1'b0;
		in_fence_flag = 1'b0;
		errors = 0;
		checks = 0;
		test_errors_base = 0;
		chained = 1'b0;
		for (int i = 0; i < 16; i++) begin
			ref_valid[i] = 1'b0;
			ref_tag[i]   = '0;
		end
		repeat (RESET_CYCLES) @(posedge clock);
		reset <= 1'b0;

		run_fetch(32'h0000_1234, 1, 1'b0, miss, saw);
		expect_refill(32'h0000_1234, 1'b1, saw);
		report_test("cold_miss");

		// whole line hits with the first three back-to-back
		run_fetch(32'h0000_1230, 1, 1'b1, miss, saw);
		expect_refill(32'h0000_1230, 1'b0, saw);
		run_fetch(32'h0000_1238, 0, 1'b1, miss, saw);
		expect_refill(32'h0000_1238, 1'b0, saw);
		run_fetch(32'h0000_123c, 0, 1'b0, miss, saw);
		expect_refill(32'h0000_123c, 1'b0, saw);
		run_fetch(32'h0000_1234, 2, 1'b0, miss, saw);
		expect_refill(32'h0000_1234, 1'b0, saw);
		report_test("hit");

		run_fetch(32'h0004_1238, 1, 1'b0, miss, saw); // index 3 with a new tag
		expect_refill(32'h0004_1238, 1'b1, saw);
		run_fetch(32'h0000_1234, 1, 1'b0, miss, saw);
		expect_refill(32'h0000_1234, 1'b1, saw);
		run_fetch(32'h0000_1230, 0, 1'b0, miss, saw);
		expect_refill(32'h0000_1230, 1'b0, saw);
		report_test("conflict_eviction");

		run_fetch(32'h0000_2050, 1, 1'b0, miss, saw);
		expect_refill(32'h0000_2050, 1'b1, saw);
		issue_fence();
		run_fetch(32'h0000_1234, 1, 1'b0, miss, saw);
		expect_refill(32'h0000_1234, 1'b1, saw);
		run_fetch(32'h0000_2054, 0, 1'b0, miss, saw);
		expect_refill(32'h0000_2054, 1'b1, saw);
		run_fetch(32'h0000_1234, 0, 1'b0, miss, saw);
		expect_refill(32'h0000_1234, 1'b0, saw);
		report_test("fence");

		for (int i = 0; i < STREAM_LEN; i++) begin
			stream_addr[i]  = make_addr($urandom_range(2), $urandom_range(5), $urandom_range(3));
			stream_fence[i] = ($urandom_range(29) == 0);
			stream_gap[i]   = ($urandom_range(1) == 0) ? 0 : int'($urandom_range(4, 1));
		end
		misses   = 0;
		ar_start = dram_ar_count;
		for (int i = 0; i < STREAM_LEN; i++) begin
			if (stream_fence[i]) begin
				issue_fence();
			end
			// hold psel only when the next fetch follows with no gap and no fence
			keep = (i < STREAM_LEN - 1) && !stream_fence[i + 1] && (stream_gap[i + 1] == 0);
			run_fetch(stream_addr[i], stream_gap[i], keep, miss, saw);
			if (miss) begin
				misses++;
			end
		end
		checks++;
		if (dram_ar_count - ar_start != misses) begin
			$display("error ar_requests expected %h got %h", misses, dram_ar_count - ar_start);
			errors++;
		end
		report_test("random_stream");

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

// ==== build.f ====
source/icache_pkg.sv
source/cache_array_if.sv
source/refill_if.sv
source/icache_arrays.sv
source/line_refill.sv
source/icache_control.sv
source/icache_top.sv
sim/axi_dram_model.sv
sim/icache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the icache testbench with Verilator, run it and grade the run by its log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module icache_tb -f build.f -o icache_sim > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/icache_sim > sim.log 2>&1 || echo "simulator returned an error"
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }
